// ==== verilog/pq_defines.svh ====
// packet queue sizes
// buffer count, word widths, buffer depth and length widths

`ifndef PQ_DEFINES_SVH
`define PQ_DEFINES_SVH

// number of packet buffers
`define PQ_N_BUF	2

`define PQ_DATA_W	64
`define PQ_WORD_W	32

// 64-bit words per buffer
`define PQ_DEPTH	32
// processor address, bit 0 picks the half word
`define PQ_ADDR_W	6
`define PQ_LEN_W	6

`endif

// ==== verilog/pq_pkg.sv ====
// packet queue shared types
// buffer and arbiter states, buffer index

`default_nettype none

`include "pq_defines.svh"

package pq_pkg;

	// life of one packet buffer
	typedef enum logic [1:0] {
		BUF_EMPTY = 2'd0,
		BUF_FILL  = 2'd1,
		BUF_PROC  = 2'd2,
		BUF_DRAIN = 2'd3
	} buf_state_t;

	typedef enum logic {
		ARB_SCAN = 1'b0,
		ARB_PROC = 1'b1
	} arb_state_t;

	typedef logic [$clog2(`PQ_N_BUF)-1:0] buf_idx_t;

endpackage

`default_nettype wire

// ==== verilog/packet_buffer.sv ====
// packet buffer
// holds one packet from fill through processor access to drain

`timescale 1ns/1ps
`default_nettype none

`include "pq_defines.svh"

module packet_buffer
	import pq_pkg::*;
(
	input  logic			clk,
	input  logic			reset,
	// fill from the input side
	input  logic			fill_start,
	input  logic			fill_wr,
	input  logic			fill_end,
	input  logic [`PQ_DATA_W-1:0]	fill_data,
	output logic			empty,
	// processor port
	output logic			proc_need,
	input  logic			proc_sel,
	input  logic			proc_we,
	input  logic			proc_wr_len,
	input  logic			proc_done,
	input  logic [`PQ_ADDR_W-1:0]	proc_addr,
	input  logic [`PQ_WORD_W-1:0]	proc_wdata,
	input  logic [`PQ_LEN_W-1:0]	proc_len,
	output logic [`PQ_WORD_W-1:0]	proc_rdata,
	// drain to the output side
	input  logic			drain_go,
	input  logic			out_rdy,
	output logic			drain_need,
	output logic			drain_wr,
	output logic			drain_bop,
	output logic			drain_eop,
	output logic [`PQ_DATA_W-1:0]	drain_data
);

	localparam int WIDX_W = `PQ_ADDR_W - 1;
	localparam logic [`PQ_LEN_W-1:0] MAX_LEN = `PQ_LEN_W'(`PQ_DEPTH);

	buf_state_t state;
	logic [`PQ_DATA_W-1:0] mem [`PQ_DEPTH];
	// words held, then the length set by the processor
	logic [`PQ_LEN_W-1:0] len;
	logic [`PQ_LEN_W-1:0] rd_ptr;
	logic fill_take;
	logic proc_access;
	logic [WIDX_W-1:0] proc_widx;
	logic [`PQ_DATA_W-1:0] proc_word;

	assign empty = (state == BUF_EMPTY);
	assign proc_need = (state == BUF_PROC);
	assign drain_need = (state == BUF_DRAIN);

	// words past the end of the buffer are dropped
	assign fill_take = (state == BUF_FILL) && fill_wr && (len < MAX_LEN);
	assign proc_access = proc_sel && (state == BUF_PROC);
	assign proc_widx = proc_addr[`PQ_ADDR_W-1:1];

	always_ff @(posedge clk) begin
		if (fill_take) begin
			mem[len[WIDX_W-1:0]] <= fill_data;
		end else if (proc_access && proc_we) begin
			// patch one half of a stored word
			if (proc_addr[0]) begin
				mem[proc_widx][`PQ_DATA_W-1:`PQ_WORD_W] <= proc_wdata;
			end else begin
				mem[proc_widx][`PQ_WORD_W-1:0] <= proc_wdata;
			end
		end
	end

	// read path, no latency
	assign proc_word = mem[proc_widx];

	always_comb begin
		proc_rdata = '0;
		if (proc_sel) begin
			if (proc_addr[0]) begin
				proc_rdata = proc_word[`PQ_DATA_W-1:`PQ_WORD_W];
			end else begin
				proc_rdata = proc_word[`PQ_WORD_W-1:0];
			end
		end
	end

	// one word per cycle while the sink is ready
	assign drain_data = mem[rd_ptr[WIDX_W-1:0]];
	assign drain_wr = (state == BUF_DRAIN) && drain_go && out_rdy;
	assign drain_bop = drain_wr && (rd_ptr == '0);
	// a zero length still sends a single word
	assign drain_eop = drain_wr && ((rd_ptr + 1'b1) >= len);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= BUF_EMPTY;
			len <= '0;
			rd_ptr <= '0;
		end else begin
			case (state)
				BUF_EMPTY: begin
					if (fill_start) begin
						state <= BUF_FILL;
						len <= '0;
					end
				end
				BUF_FILL: begin
					if (fill_take) begin
						len <= len + 1'b1;
					end
					if (fill_end) begin
						state <= BUF_PROC;
					end
				end
				BUF_PROC: begin
					if (proc_access && proc_wr_len) begin
						if (proc_len > MAX_LEN) begin
							len <= MAX_LEN;
						end else begin
							len <= proc_len;
						end
					end
					if (proc_access && proc_done) begin
						state <= BUF_DRAIN;
						rd_ptr <= '0;
					end
				end
				BUF_DRAIN: begin
					if (drain_eop) begin
						state <= BUF_EMPTY;
					end else if (drain_wr) begin
						rd_ptr <= rd_ptr + 1'b1;
					end
				end
				default: begin
					state <= BUF_EMPTY;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/in_steer.sv ====
// input steering
// puts an arriving packet into an empty buffer, answers in_req/in_ack

`timescale 1ns/1ps
`default_nettype none

`include "pq_defines.svh"

module in_steer
	import pq_pkg::*;
(
	input  logic			clk,
	input  logic			reset,
	input  logic			in_req,
	input  logic			in_wr,
	input  logic [`PQ_N_BUF-1:0]	empty,
	output logic			in_ack,
	output logic [`PQ_N_BUF-1:0]	fill_start,
	output logic [`PQ_N_BUF-1:0]	fill_wr,
	output logic [`PQ_N_BUF-1:0]	fill_end
);

	logic active;
	logic start;
	buf_idx_t sel;
	buf_idx_t pick;

	// lowest-numbered empty buffer
	always_comb begin
		pick = '0;
		for (int i = `PQ_N_BUF - 1; i >= 0; i--) begin
			if (empty[i]) begin
				pick = buf_idx_t'(i);
			end
		end
	end

	assign start = !active && in_req && (|empty);
	assign in_ack = active && in_req;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			sel <= '0;
		end else if (start) begin
			active <= 1'b1;
			sel <= pick;
		end else if (active && !in_req) begin
			// packet closed
			active <= 1'b0;
		end
	end

	always_comb begin
		for (int i = 0; i < `PQ_N_BUF; i++) begin
			fill_start[i] = start && (pick == buf_idx_t'(i));
			fill_wr[i] = in_ack && in_wr && (sel == buf_idx_t'(i));
			fill_end[i] = active && !in_req && (sel == buf_idx_t'(i));
		end
	end

endmodule

`default_nettype wire

// ==== verilog/proc_arbiter.sv ====
// processor arbiter
// scans the buffers in turn and steers the processor port to the granted one

`timescale 1ns/1ps
`default_nettype none

`include "pq_defines.svh"

module proc_arbiter
	import pq_pkg::*;
(
	input  logic					clk,
	input  logic					reset,
	input  logic [`PQ_N_BUF-1:0]			proc_need,
	input  logic					pq_done,
	input  logic					pq_we,
	input  logic					pq_wr_pkt_len,
	output logic					pq_req,
	output logic [`PQ_N_BUF-1:0]			proc_sel,
	output logic [`PQ_N_BUF-1:0]			proc_we,
	output logic [`PQ_N_BUF-1:0]			proc_wr_len,
	output logic [`PQ_N_BUF-1:0]			proc_done,
	input  logic [`PQ_N_BUF-1:0][`PQ_WORD_W-1:0]	proc_rdata,
	output logic [`PQ_WORD_W-1:0]			pq_data_out
);

	arb_state_t state;
	buf_idx_t cur;

	// one buffer index per cycle until one needs the processor
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ARB_SCAN;
			cur <= '0;
		end else begin
			case (state)
				ARB_SCAN: begin
					if (proc_need[cur]) begin
						state <= ARB_PROC;
					end else if (cur == buf_idx_t'(`PQ_N_BUF - 1)) begin
						cur <= '0;
					end else begin
						cur <= cur + 1'b1;
					end
				end
				ARB_PROC: begin
					if (pq_done) begin
						state <= ARB_SCAN;
					end
				end
				default: begin
					state <= ARB_SCAN;
				end
			endcase
		end
	end

	assign pq_req = (state == ARB_PROC);

	// strobes reach the granted buffer only
	always_comb begin
		for (int i = 0; i < `PQ_N_BUF; i++) begin
			proc_sel[i] = pq_req && (cur == buf_idx_t'(i));
			proc_we[i] = proc_sel[i] && pq_we;
			proc_wr_len[i] = proc_sel[i] && pq_wr_pkt_len;
			proc_done[i] = proc_sel[i] && pq_done;
		end
	end

	assign pq_data_out = pq_req ? proc_rdata[cur] : '0;

endmodule

`default_nettype wire

// ==== verilog/out_merge.sv ====
// output merger
// picks the next draining buffer round robin and muxes its stream out

`timescale 1ns/1ps
`default_nettype none

`include "pq_defines.svh"

module out_merge
	import pq_pkg::*;
(
	input  logic					clk,
	input  logic					reset,
	input  logic [`PQ_N_BUF-1:0]			drain_need,
	input  logic [`PQ_N_BUF-1:0]			drain_wr,
	input  logic [`PQ_N_BUF-1:0]			drain_bop,
	input  logic [`PQ_N_BUF-1:0]			drain_eop,
	input  logic [`PQ_N_BUF-1:0][`PQ_DATA_W-1:0]	drain_data,
	input  logic					out_ack,
	output logic					out_req,
	output logic [`PQ_N_BUF-1:0]			drain_go,
	output logic					out_wr,
	output logic					out_bop,
	output logic					out_eop,
	output logic [`PQ_DATA_W-1:0]			out_data
);

	logic busy;
	logic found;
	buf_idx_t sel;
	buf_idx_t last;
	buf_idx_t pick;
	buf_idx_t cand;

	// nearest waiting buffer after the last one served
	always_comb begin
		pick = last;
		found = 1'b0;
		cand = last;
		for (int k = `PQ_N_BUF; k >= 1; k--) begin
			cand = buf_idx_t'((int'(last) + k) % `PQ_N_BUF);
			if (drain_need[cand]) begin
				pick = cand;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			out_req <= 1'b0;
			sel <= '0;
			last <= buf_idx_t'(`PQ_N_BUF - 1);
		end else if (!busy) begin
			if (found) begin
				busy <= 1'b1;
				out_req <= 1'b1;
				sel <= pick;
			end
		end else if (out_req) begin
			if (out_ack) begin
				out_req <= 1'b0;
			end
		end else if (out_eop) begin
			// buffer empties on this same edge
			busy <= 1'b0;
			last <= sel;
		end
	end

	always_comb begin
		for (int i = 0; i < `PQ_N_BUF; i++) begin
			drain_go[i] = busy && !out_req && (sel == buf_idx_t'(i));
		end
	end

	assign out_wr = busy && drain_wr[sel];
	assign out_bop = busy && drain_bop[sel];
	assign out_eop = busy && drain_eop[sel];
	assign out_data = drain_data[sel];

endmodule

`default_nettype wire

// ==== verilog/packet_queue.sv ====
// packet queue top
// input steering, packet buffers, processor arbiter and output merger

`timescale 1ns/1ps
`default_nettype none

`include "pq_defines.svh"

module packet_queue (
	input  logic			clk,
	input  logic			reset,
	// packet source
	input  logic [`PQ_DATA_W-1:0]	in_data,
	input  logic			in_req,
	input  logic			in_wr,
	output logic			in_ack,
	// processor
	input  logic [`PQ_ADDR_W-1:0]	pq_addr,
	input  logic [`PQ_WORD_W-1:0]	pq_data_in,
	input  logic			pq_we,
	input  logic			pq_done,
	input  logic			pq_wr_pkt_len,
	input  logic [`PQ_LEN_W-1:0]	pq_pkt_len,
	output logic			pq_req,
	output logic [`PQ_WORD_W-1:0]	pq_data_out,
	// packet sink
	input  logic			out_ack,
	input  logic			out_rdy,
	output logic			out_req,
	output logic			out_wr,
	output logic			out_bop,
	output logic			out_eop,
	output logic [`PQ_DATA_W-1:0]	out_data
);

	logic [`PQ_N_BUF-1:0] empty;
	logic [`PQ_N_BUF-1:0] fill_start;
	logic [`PQ_N_BUF-1:0] fill_wr;
	logic [`PQ_N_BUF-1:0] fill_end;

	logic [`PQ_N_BUF-1:0] proc_need;
	logic [`PQ_N_BUF-1:0] proc_sel;
	logic [`PQ_N_BUF-1:0] proc_we;
	logic [`PQ_N_BUF-1:0] proc_wr_len;
	logic [`PQ_N_BUF-1:0] proc_done;
	logic [`PQ_N_BUF-1:0][`PQ_WORD_W-1:0] proc_rdata;

	logic [`PQ_N_BUF-1:0] drain_need;
	logic [`PQ_N_BUF-1:0] drain_go;
	logic [`PQ_N_BUF-1:0] drain_wr;
	logic [`PQ_N_BUF-1:0] drain_bop;
	logic [`PQ_N_BUF-1:0] drain_eop;
	logic [`PQ_N_BUF-1:0][`PQ_DATA_W-1:0] drain_data;

	in_steer u_in_steer (
		.clk		(clk),
		.reset		(reset),
		.in_req		(in_req),
		.in_wr		(in_wr),
		.empty		(empty),
		.in_ack		(in_ack),
		.fill_start	(fill_start),
		.fill_wr	(fill_wr),
		.fill_end	(fill_end)
	);

	// input data, address, write data and length go to every buffer
	for (genvar i = 0; i < `PQ_N_BUF; i++) begin : g_buf
		packet_buffer u_buf (
			.clk		(clk),
			.reset		(reset),
			.fill_start	(fill_start[i]),
			.fill_wr	(fill_wr[i]),
			.fill_end	(fill_end[i]),
			.fill_data	(in_data),
			.empty		(empty[i]),
			.proc_need	(proc_need[i]),
			.proc_sel	(proc_sel[i]),
			.proc_we	(proc_we[i]),
			.proc_wr_len	(proc_wr_len[i]),
			.proc_done	(proc_done[i]),
			.proc_addr	(pq_addr),
			.proc_wdata	(pq_data_in),
			.proc_len	(pq_pkt_len),
			.proc_rdata	(proc_rdata[i]),
			.drain_go	(drain_go[i]),
			.out_rdy	(out_rdy),
			.drain_need	(drain_need[i]),
			.drain_wr	(drain_wr[i]),
			.drain_bop	(drain_bop[i]),
			.drain_eop	(drain_eop[i]),
			.drain_data	(drain_data[i])
		);
	end

	proc_arbiter u_proc_arbiter (
		.clk		(clk),
		.reset		(reset),
		.proc_need	(proc_need),
		.pq_done	(pq_done),
		.pq_we		(pq_we),
		.pq_wr_pkt_len	(pq_wr_pkt_len),
		.pq_req		(pq_req),
		.proc_sel	(proc_sel),
		.proc_we	(proc_we),
		.proc_wr_len	(proc_wr_len),
		.proc_done	(proc_done),
		.proc_rdata	(proc_rdata),
		.pq_data_out	(pq_data_out)
	);

	out_merge u_out_merge (
		.clk		(clk),
		.reset		(reset),
		.drain_need	(drain_need),
		.drain_wr	(drain_wr),
		.drain_bop	(drain_bop),
		.drain_eop	(drain_eop),
		.drain_data	(drain_data),
		.out_ack	(out_ack),
		.out_req	(out_req),
		.drain_go	(drain_go),
		.out_wr		(out_wr),
		.out_bop	(out_bop),
		.out_eop	(out_eop),
		.out_data	(out_data)
	);

endmodule

`default_nettype wire

// ==== tests/packet_queue_checker.sv ====
// packet queue checker
// handshake and output framing assertions, bound to the top level

`timescale 1ns/1ps
`default_nettype none

`include "pq_defines.svh"

module packet_queue_checker (
	input logic			clk,
	input logic			reset,
	input logic			in_req,
	input logic			in_ack,
	input logic			pq_req,
	input logic [`PQ_WORD_W-1:0]	pq_data_out,
	input logic			out_rdy,
	input logic			out_wr,
	input logic			out_bop,
	input logic			out_eop
);

	// words leave only while the sink is ready
	a_wr_rdy: assert property (@(posedge clk) disable iff (reset) out_wr |-> out_rdy)
		else $error("out_wr high while out_rdy is low");

	a_bop_wr: assert property (@(posedge clk) disable iff (reset) out_bop |-> out_wr)
		else $error("out_bop high without out_wr");

	a_eop_wr: assert property (@(posedge clk) disable iff (reset) out_eop |-> out_wr)
		else $error("out_eop high without out_wr");

	a_ack_req: assert property (@(posedge clk) disable iff (reset) in_ack |-> in_req)
		else $error("in_ack high without in_req");

	// no grant, no read data
	a_rdata_idle: assert property (@(posedge clk) disable iff (reset)
		!pq_req |-> (pq_data_out == '0))
		else $error("pq_data_out not zero while pq_req is low");

endmodule

bind packet_queue packet_queue_checker u_checker (
	.clk		(clk),
	.reset		(reset),
	.in_req		(in_req),
	.in_ack		(in_ack),
	.pq_req		(pq_req),
	.pq_data_out	(pq_data_out),
	.out_rdy	(out_rdy),
	.out_wr		(out_wr),
	.out_bop	(out_bop),
	.out_eop	(out_eop)
);

`default_nettype wire

// ==== tests/packet_queue_tb.sv ====
// packet queue testbench
// directed tests of fill, processor access, drain and two packets in flight

`timescale 1ns/1ps
`default_nettype none

`include "pq_defines.svh"

module packet_queue_tb;

	localparam logic [31:0] SEED = 32'h15d2bf4e;
	// 8 + 16 + 5 + 6 + 7 words in five packets
	localparam int TOTAL_WORDS = 42;
	localparam int TOTAL_PKTS = 5;
	// a fill, two reads and a throttled drain per word, plus handshakes per packet
	localparam int CYCLE_LIMIT = 10 * TOTAL_WORDS + 50 * TOTAL_PKTS + 100;

	logic clk;
	logic reset;
	logic [`PQ_DATA_W-1:0] in_data;
	logic in_req;
	logic in_wr;
	logic in_ack;
	logic [`PQ_ADDR_W-1:0] pq_addr;
	logic [`PQ_WORD_W-1:0] pq_data_in;
	logic pq_we;
	logic pq_done;
	logic pq_wr_pkt_len;
	logic [`PQ_LEN_W-1:0] pq_pkt_len;
	logic pq_req;
	logic [`PQ_WORD_W-1:0] pq_data_out;
	logic out_ack;
	logic out_rdy;
	logic out_req;
	logic out_wr;
	logic out_bop;
	logic out_eop;
	logic [`PQ_DATA_W-1:0] out_data;

	logic [31:0] lfsr_state;
	int error_count;
	int check_count;
	int cycle_count;
	// expected packets, one slot each
	logic [`PQ_DATA_W-1:0] pkt_words [4][`PQ_DEPTH];
	int pkt_len [4];
	bit pkt_seen [4];
	logic [`PQ_DATA_W-1:0] rx_words [`PQ_DEPTH];
	int rx_count;

	packet_queue uut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: tests still running after %0d clock cycles", CYCLE_LIMIT);
		$display("TEST FAIL");
		$finish;
	end

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	task automatic random_bits(input int n, output logic [63:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[62:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string msg);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t ns: %s (got %h, expected %h)",
				$time, msg, actual, expected);
		end
	endtask

	function automatic int find_slot(input logic [63:0] first_word, input int first,
			input int last);
		int slot;
		slot = -1;
		for (int s = first; s <= last; s++) begin
			if (pkt_len[s] > 0 && pkt_words[s][0] == first_word) begin
				slot = s;
			end
		end
		return slot;
	endfunction

	task automatic make_packet(input int slot, input int n);
		logic [63:0] w;
		for (int i = 0; i < n; i++) begin
			random_bits(64, w);
			pkt_words[slot][i] = w;
		end
		pkt_len[slot] = n;
		pkt_seen[slot] = 1'b0;
	endtask

	task automatic send_packet(input int slot);
		in_req = 1'b1;
		next_cycle();
		while (!in_ack) begin
			next_cycle();
		end
		for (int i = 0; i < pkt_len[slot]; i++) begin
			in_data = pkt_words[slot][i];
			in_wr = 1'b1;
			next_cycle();
		end
		in_wr = 1'b0;
		in_data = '0;
		in_req = 1'b0;
		next_cycle();
		check_value(in_ack, 1'b0, "in_ack after in_req fell");
	endtask

	task automatic read_half(input int addr, output logic [`PQ_WORD_W-1:0] data);
		pq_addr = `PQ_ADDR_W'(addr);
		#1;
		data = pq_data_out;
		next_cycle();
	endtask

	task automatic proc_write(input int addr, input logic [`PQ_WORD_W-1:0] data);
		pq_addr = `PQ_ADDR_W'(addr);
		pq_data_in = data;
		pq_we = 1'b1;
		next_cycle();
		pq_we = 1'b0;
	endtask

	task automatic set_length(input int len);
		pq_pkt_len = `PQ_LEN_W'(len);
		pq_wr_pkt_len = 1'b1;
		next_cycle();
		pq_wr_pkt_len = 1'b0;
	endtask

	task automatic wait_grant();
		while (!pq_req) begin
			next_cycle();
		end
	endtask

	// every half word as seen through the processor port
	task automatic check_proc_view(input int slot);
		logic [`PQ_WORD_W-1:0] half;
		for (int k = 0; k < pkt_len[slot]; k++) begin
			read_half(2 * k, half);
			check_value(half, pkt_words[slot][k][31:0], $sformatf("low half of word %0d", k));
			read_half(2 * k + 1, half);
			check_value(half, pkt_words[slot][k][63:32],
				$sformatf("high half of word %0d", k));
		end
	endtask

	task automatic finish_processing();
		pq_done = 1'b1;
		next_cycle();
		pq_done = 1'b0;
		check_value(pq_req, 1'b0, "pq_req in the cycle after pq_done");
	endtask

	task automatic serve_any(input int first, input int last);
		logic [`PQ_WORD_W-1:0] lo;
		logic [`PQ_WORD_W-1:0] hi;
		int slot;
		wait_grant();
		read_half(0, lo);
		read_half(1, hi);
		slot = find_slot({hi, lo}, first, last);
		if (slot < 0) begin
			error_count++;
			$display("processor at %0t ns sees a packet that was never sent", $time);
		end else begin
			check_proc_view(slot);
		end
		finish_processing();
	endtask

	task automatic receive_packet(input int first, input int last, input bit throttle);
		logic [63:0] bits;
		int slot;
		bit done;
		while (!out_req) begin
			next_cycle();
		end
		out_rdy = 1'b1;
		out_ack = 1'b1;
		#1;
		check_value(out_wr, 1'b0, "out_wr in the out_ack cycle");
		next_cycle();
		out_ack = 1'b0;
		rx_count = 0;
		done = 1'b0;
		while (!done) begin
			out_rdy = 1'b1;
			if (throttle) begin
				random_bits(1, bits);
				out_rdy = bits[0];
			end
			#1;
			if (out_wr) begin
				check_value(out_bop, rx_count == 0, "out_bop only on the first word");
				rx_words[rx_count] = out_data;
				rx_count++;
				done = out_eop;
			end
			if (!done && rx_count >= `PQ_DEPTH) begin
				error_count++;
				$display("output packet has no end of packet mark within the buffer depth");
				done = 1'b1;
			end
			next_cycle();
		end
		out_rdy = 1'b0;
		slot = find_slot(rx_words[0], first, last);
		if (slot < 0) begin
			error_count++;
			$display("output packet at %0t ns matches no packet that was sent", $time);
		end else begin
			if (pkt_seen[slot]) begin
				error_count++;
				$display("packet in slot %0d came out twice", slot);
			end
			pkt_seen[slot] = 1'b1;
			check_value(rx_count, pkt_len[slot], "output packet length");
			for (int i = 0; i < rx_count && i < pkt_len[slot]; i++) begin
				check_value(rx_words[i], pkt_words[slot][i], $sformatf("output word %0d", i));
			end
		end
	endtask

	task automatic test_reset_state();
		check_value(in_ack, 1'b0, "in_ack after reset");
		check_value(pq_req, 1'b0, "pq_req after reset");
		check_value(out_req, 1'b0, "out_req after reset");
		check_value(out_wr, 1'b0, "out_wr after reset");
	endtask

	task automatic test_fill_and_read();
		make_packet(0, 8);
		send_packet(0);
		wait_grant();
		check_proc_view(0);
	endtask

	// packet from the previous test is still granted
	task automatic test_patch_and_length();
		logic [63:0] v;
		logic [`PQ_WORD_W-1:0] half;
		random_bits(32, v);
		proc_write(7, v[31:0]);
		pkt_words[0][3][63:32] = v[31:0];
		read_half(7, half);
		check_value(half, v[31:0], "patched high half of word 3");
		set_length(6);
		pkt_len[0] = 6;
		finish_processing();
		receive_packet(0, 0, 1'b0);
	endtask

	task automatic test_back_pressure();
		make_packet(0, 16);
		send_packet(0);
		serve_any(0, 0);
		receive_packet(0, 0, 1'b1);
	endtask

	task automatic test_two_in_flight();
		make_packet(1, 5);
		make_packet(2, 6);
		make_packet(3, 7);
		send_packet(1);
		send_packet(2);
		// both buffers hold a packet, third source must wait
		in_req = 1'b1;
		repeat (10) begin
			next_cycle();
			check_value(in_ack, 1'b0, "in_ack while both buffers are full");
		end
		serve_any(1, 2);
		receive_packet(1, 2, 1'b0);
		send_packet(3);
		serve_any(1, 3);
		serve_any(1, 3);
		receive_packet(1, 3, 1'b1);
		receive_packet(1, 3, 1'b1);
		for (int s = 1; s <= 3; s++) begin
			if (!pkt_seen[s]) begin
				error_count++;
				$display("packet in slot %0d never came out", s);
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		in_data = '0;
		in_req = 1'b0;
		in_wr = 1'b0;
		pq_addr = '0;
		pq_data_in = '0;
		pq_we = 1'b0;
		pq_done = 1'b0;
		pq_wr_pkt_len = 1'b0;
		pq_pkt_len = '0;
		out_ack = 1'b0;
		out_rdy = 1'b0;
		lfsr_state = SEED;
		error_count = 0;
		check_count = 0;
		for (int s = 0; s < 4; s++) begin
			pkt_len[s] = 0;
			pkt_seen[s] = 1'b0;
		end
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		next_cycle();

		test_reset_state();
		test_fill_and_read();
		test_patch_and_length();
		test_back_pressure();
		test_two_in_flight();

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== packet_queue.f ====
+incdir+verilog
verilog/pq_pkg.sv
verilog/packet_buffer.sv
verilog/in_steer.sv
verilog/proc_arbiter.sv
verilog/out_merge.sv
verilog/packet_queue.sv
tests/packet_queue_checker.sv
tests/packet_queue_tb.sv

// ==== Makefile ====
TOP = packet_queue_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f packet_queue.f \
		--top-module $(TOP) -o sim
	./obj_dir/sim > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
